//--- all.f
stream_pkg.sv
fifo_rd_if.sv
sync_fifo.sv
rr_merger.sv
dual_stream_merge.sv
dual_stream_merge_props.sv
tb_dual_stream_merge.sv

//--- Makefile
VERILATOR ?= verilator
FLAGS     := --binary --timing --assert -j 0
TOP       := tb_dual_stream_merge
FILELIST  := all.f
BUILD_DIR := obj_dir
SIM       := $(BUILD_DIR)/V$(TOP)
LOG       := sim.log
PASS_MSG  := ALL TESTS PASSED

SOURCES   := $(shell grep -v '^+' $(FILELIST))

.PHONY: all build run clean

all: run

build: $(SIM)

# Rebuilt only when a source or the file list changes
$(SIM): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(FLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(SIM)
	./$(SIM) > $(LOG) 2>&1; cat $(LOG)
	@if grep -qx "$(PASS_MSG)" $(LOG); then \
		echo "Simulation result: pass"; \
	else \
		echo "Simulation result: fail"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- tb_dual_stream_merge.sv
`timescale 1ns/100ps
`default_nettype none

module tb_dual_stream_merge;

    localparam int DEPTH        = 8;
    localparam int LVL_BITS     = $clog2(DEPTH + 1);
    localparam int CLK_PERIOD   = 100;
    localparam int DRIVE_DELAY  = 10;
    localparam int RESET_CYCLES = 16;
    localparam int RAND_CYCLES  = 400;
    localparam int FAIR_CYCLES  = 40;
    localparam int OVF_CYCLES   = 32;
    localparam int DRAIN_LIMIT  = 4 * DEPTH + 8;
    localparam int IDLE_CYCLES  = 10;
    // Every phase at its longest plus margin
    localparam int TOTAL_CYCLES = RESET_CYCLES + 20 + RAND_CYCLES + FAIR_CYCLES + OVF_CYCLES
                                  + 3 * (DRAIN_LIMIT + 1) + IDLE_CYCLES + 100;

    logic                  clk;
    logic                  rst_n;
    logic                  a_wr_en;
    stream_pkg::word_t     a_data;
    logic                  a_full;
    logic [LVL_BITS-1:0]   a_level;
    logic                  b_wr_en;
    stream_pkg::word_t     b_data;
    logic                  b_full;
    logic [LVL_BITS-1:0]   b_level;
    logic                  out_valid;
    stream_pkg::word_t     out_data;
    stream_pkg::chan_t     out_chan;

    // Words written but not yet seen at the output
    stream_pkg::word_t     q_a [$];
    stream_pkg::word_t     q_b [$];
    // Modelled FIFO occupancy and merger state
    int                    cnt_a;
    int                    cnt_b;
    logic                  last_b;
    logic                  exp_valid;
    stream_pkg::chan_t     exp_chan;
    int                    drops_a = 0;
    int                    drops_b = 0;
    logic                  saw_a_full = 1'b0;
    int                    checks = 0;
    int                    errors = 0;
    int                    prop_fails = 0;
    logic [31:0]           lfsr_state;

    dual_stream_merge #(
        .DEPTH (DEPTH)
    ) dut (
        .clk       (clk),
        .rst_n     (rst_n),
        .a_wr_en   (a_wr_en),
        .a_data    (a_data),
        .a_full    (a_full),
        .a_level   (a_level),
        .b_wr_en   (b_wr_en),
        .b_data    (b_data),
        .b_full    (b_full),
        .b_level   (b_level),
        .out_valid (out_valid),
        .out_data  (out_data),
        .out_chan  (out_chan)
    );

    initial
    begin
        clk = 1'b0;
        forever
        begin
            #(CLK_PERIOD / 2) clk = ~clk;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Random source and drive helpers
    //////////////////////////////////////////////////////////////////////

    // Galois LFSR shifting right by one step per bit
    function automatic logic lfsr_bit();
        logic bit_out;
        bit_out = lfsr_state[0];
        lfsr_state = {1'b0, lfsr_state[31:1]} ^ (bit_out ? 32'h8020_0003 : 32'h0);
        return bit_out;
    endfunction

    function automatic stream_pkg::word_t rand_word();
        stream_pkg::word_t w;
        int i;
        for (i = 0; i < stream_pkg::WORD_BITS; i++)
        begin
            w[i] = lfsr_bit();
        end
        return w;
    endfunction

    // Inputs change a little after the rising edge
    task automatic next_cycle();
        @(posedge clk);
        #DRIVE_DELAY;
    endtask

    task automatic set_inputs(input logic a_en, input stream_pkg::word_t a_d,
                              input logic b_en, input stream_pkg::word_t b_d);
        a_wr_en = a_en;
        a_data  = a_d;
        b_wr_en = b_en;
        b_data  = b_d;
    endtask

    //////////////////////////////////////////////////////////////////////
    // Reference model and checks at the falling edge
    //////////////////////////////////////////////////////////////////////

    task automatic check_output();
        stream_pkg::word_t head;
        logic have;
        head = '0;
        have = 1'b0;
        checks++;
        assert (out_valid == exp_valid) else
        begin
            errors++;
            $display("Mismatch at %0t: out_valid %b, expected %b", $time, out_valid, exp_valid);
        end
        if (out_valid)
        begin
            checks++;
            assert (out_chan == exp_chan) else
            begin
                errors++;
                $display("Mismatch at %0t: out_chan %0d, expected %0d", $time, out_chan, exp_chan);
            end
            // Pop from the queue the DUT claims as source
            if (out_chan == stream_pkg::CHAN_B)
            begin
                have = (q_b.size() != 0);
                if (have)
                    head = q_b.pop_front();
            end
            else
            begin
                have = (q_a.size() != 0);
                if (have)
                    head = q_a.pop_front();
            end
            checks++;
            assert (have) else
            begin
                errors++;
                $display("Output on channel %0d at %0t with no word outstanding", out_chan, $time);
            end
            if (have)
            begin
                assert (out_data == head) else
                begin
                    errors++;
                    $display("Mismatch at %0t: out_data %h, expected %h", $time, out_data, head);
                end
            end
        end
    endtask

    task automatic check_levels();
        checks++;
        assert (a_level == LVL_BITS'(cnt_a) && a_full == (cnt_a == DEPTH)
                && b_level == LVL_BITS'(cnt_b) && b_full == (cnt_b == DEPTH)) else
        begin
            errors++;
            $display("Mismatch at %0t: levels %0d/%0d full %b/%b, expected levels %0d/%0d",
                     $time, a_level, b_level, a_full, b_full, cnt_a, cnt_b);
        end
        if (a_full)
            saw_a_full = 1'b1;
    endtask

    // One edge of FIFO and merger behaviour from the pre-edge state
    task automatic step_model();
        logic ne_a;
        logic ne_b;
        logic pick_b;
        logic rd_a;
        logic rd_b;
        ne_a = (cnt_a != 0);
        ne_b = (cnt_b != 0);
        // Tie goes to the channel not served last
        pick_b = (ne_a && ne_b) ? !last_b : ne_b;
        rd_a = ne_a && !pick_b;
        rd_b = ne_b && pick_b;
        // Writes only land below DEPTH even with a read at the same edge
        if (a_wr_en)
        begin
            if (cnt_a < DEPTH)
            begin
                q_a.push_back(a_data);
                cnt_a++;
            end
            else
                drops_a++;
        end
        if (b_wr_en)
        begin
            if (cnt_b < DEPTH)
            begin
                q_b.push_back(b_data);
                cnt_b++;
            end
            else
                drops_b++;
        end
        if (rd_a)
            cnt_a--;
        if (rd_b)
            cnt_b--;
        // Word shows up one cycle after its read edge
        exp_valid = rd_a || rd_b;
        if (exp_valid)
        begin
            exp_chan = rd_b;
            last_b   = rd_b;
        end
    endtask

    always @(negedge clk)
    begin
        if (rst_n)
        begin
            // Channel a wins the first tie out of reset
            cnt_a     = 0;
            cnt_b     = 0;
            last_b    = 1'b1;
            exp_valid = 1'b0;
            exp_chan  = stream_pkg::CHAN_A;
            q_a.delete();
            q_b.delete();
        end
        else
        begin
            check_output();
            check_levels();
            step_model();
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Test phases
    //////////////////////////////////////////////////////////////////////

    // One word into an idle design shows up exactly one cycle after its read edge
    task automatic check_single_latency(input stream_pkg::chan_t chan,
                                        input stream_pkg::word_t value);
        repeat (4)
            next_cycle();
        if (chan == stream_pkg::CHAN_B)
            set_inputs(1'b0, '0, 1'b1, value);
        else
            set_inputs(1'b1, value, 1'b0, '0);
        @(posedge clk);
        #DRIVE_DELAY;
        set_inputs(1'b0, '0, 1'b0, '0);
        @(negedge clk);
        checks++;
        assert (!out_valid) else
        begin
            errors++;
            $display("Mismatch at %0t: out_valid one cycle early", $time);
        end
        @(negedge clk);
        checks++;
        assert (out_valid && out_data == value && out_chan == chan) else
        begin
            errors++;
            $display("Mismatch at %0t: single word valid %b data %h chan %0d, expected %h on %0d",
                     $time, out_valid, out_data, out_chan, value, chan);
        end
    endtask

    task automatic run_overflow_burst();
        int i;
        int drops_before;
        drops_before = drops_a;
        saw_a_full   = 1'b0;
        // Channel b keeps the merger alternating while channel a is pushed every cycle
        for (i = 0; i < OVF_CYCLES; i++)
        begin
            next_cycle();
            set_inputs(1'b1, rand_word(), (i < 10), rand_word());
        end
        checks++;
        assert (saw_a_full && drops_a > drops_before) else
        begin
            errors++;
            $display("Channel a never filled up and dropped words during the overflow burst");
        end
    endtask

    task automatic wait_drain();
        int n;
        n = 0;
        next_cycle();
        set_inputs(1'b0, '0, 1'b0, '0);
        while ((q_a.size() != 0 || q_b.size() != 0) && n < DRAIN_LIMIT)
        begin
            @(posedge clk);
            n++;
        end
        checks++;
        assert (q_a.size() == 0 && q_b.size() == 0) else
        begin
            errors++;
            $display("Drain did not finish in %0d cycles, %0d words on a and %0d on b left",
                     DRAIN_LIMIT, q_a.size(), q_b.size());
        end
    endtask

    initial
    begin
        rst_n      = 1'b1;
        lfsr_state = 32'ha775_812a;
        set_inputs(1'b0, '0, 1'b0, '0);
        repeat (RESET_CYCLES)
            @(posedge clk);
        #DRIVE_DELAY;
        rst_n = 1'b0;

        check_single_latency(stream_pkg::CHAN_A, 8'h5a);
        check_single_latency(stream_pkg::CHAN_B, 8'ha5);

        // Random interleaved writes on both channels
        repeat (RAND_CYCLES)
        begin
            next_cycle();
            set_inputs(lfsr_bit(), rand_word(), lfsr_bit(), rand_word());
        end
        wait_drain();

        // Both producers at full rate so both FIFOs stay backlogged
        repeat (FAIR_CYCLES)
        begin
            next_cycle();
            set_inputs(1'b1, rand_word(), 1'b1, rand_word());
        end
        wait_drain();

        run_overflow_burst();
        wait_drain();

        // Fully drained design stays quiet
        repeat (IDLE_CYCLES)
        begin
            @(negedge clk);
            checks++;
            assert (!out_valid && a_level == '0 && b_level == '0 && !a_full && !b_full) else
            begin
                errors++;
                $display("Mismatch at %0t: not idle after drain, out_valid %b levels %0d/%0d",
                         $time, out_valid, a_level, b_level);
            end
        end

        prop_fails = dut.u_props.fail_count;
        $display("Checks %0d, errors %0d, property failures %0d, dropped a %0d b %0d",
                 checks, errors, prop_fails, drops_a, drops_b);
        if (errors == 0 && prop_fails == 0)
        begin
            $display("ALL TESTS PASSED");
        end
        else
        begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

    // Watchdog
    initial
    begin
        #(TOTAL_CYCLES * CLK_PERIOD);
        $display("Timeout: the run did not finish within %0d clock cycles", TOTAL_CYCLES);
        $display("SOME TESTS FAILED");
        $finish;
    end

endmodule

`default_nettype wire

//--- dual_stream_merge_props.sv
`timescale 1ns/100ps
`default_nettype none

// Level, flag, reset and fairness properties on the merger top level
module dual_stream_merge_props #(
    parameter int DEPTH = 8
) (
    input wire logic                         clk,
    input wire logic                         rst_n,
    input wire logic                         a_full,
    input wire logic [$clog2(DEPTH + 1)-1:0] a_level,
    input wire logic                         b_full,
    input wire logic [$clog2(DEPTH + 1)-1:0] b_level,
    input wire logic                         out_valid,
    input wire stream_pkg::chan_t            out_chan
);

    localparam int LVL_BITS = $clog2(DEPTH + 1);
    localparam logic [LVL_BITS-1:0] LVL_FULL = LVL_BITS'(DEPTH);

    // Count of failed assertions over the run
    int fail_count = 0;

    // Both FIFOs held data at the previous edge and at the one before
    logic busy_q1;
    logic busy_q2;

    always_ff @(posedge clk or posedge rst_n)
    begin
        if (rst_n)
        begin
            busy_q1 <= 1'b0;
            busy_q2 <= 1'b0;
        end
        else
        begin
            busy_q1 <= (a_level != '0) && (b_level != '0);
            busy_q2 <= busy_q1;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Occupancy and flags
    //////////////////////////////////////////////////////////////////////

    a_level_range: assert property (@(posedge clk) disable iff (rst_n) a_level <= LVL_FULL)
    else
    begin
        $error("channel a level above DEPTH");
        fail_count++;
    end

    b_level_range: assert property (@(posedge clk) disable iff (rst_n) b_level <= LVL_FULL)
    else
    begin
        $error("channel b level above DEPTH");
        fail_count++;
    end

    a_full_flag: assert property (@(posedge clk) disable iff (rst_n)
        a_full == (a_level == LVL_FULL))
    else
    begin
        $error("a_full disagrees with a_level");
        fail_count++;
    end

    b_full_flag: assert property (@(posedge clk) disable iff (rst_n)
        b_full == (b_level == LVL_FULL))
    else
    begin
        $error("b_full disagrees with b_level");
        fail_count++;
    end

    //////////////////////////////////////////////////////////////////////
    // Output stream
    //////////////////////////////////////////////////////////////////////

    // Nothing comes out in the first cycle out of reset
    quiet_after_reset: assert property (@(posedge clk) $fell(rst_n) |-> !out_valid)
    else
    begin
        $error("out_valid high right after reset release");
        fail_count++;
    end

    // Two back-to-back reads under full backlog serve different channels
    fair_alternation: assert property (@(posedge clk) disable iff (rst_n)
        (busy_q1 && busy_q2) |-> (out_valid && $past(out_valid) && out_chan != $past(out_chan)))
    else
    begin
        $error("backlogged outputs did not alternate channels");
        fail_count++;
    end

endmodule

bind dual_stream_merge dual_stream_merge_props #(
    .DEPTH     (DEPTH)
) u_props (
    .clk       (clk),
    .rst_n     (rst_n),
    .a_full    (a_full),
    .a_level   (a_level),
    .b_full    (b_full),
    .b_level   (b_level),
    .out_valid (out_valid),
    .out_chan  (out_chan)
);

`default_nettype wire

//--- dual_stream_merge.sv
`timescale 1ns/100ps
`default_nettype none

// Two producers into two FIFOs, merged round-robin into one tagged stream
module dual_stream_merge #(
    parameter int DEPTH = 8
) (
    input  wire logic                           clk,
    input  wire logic                           rst_n,

    // Producer a
    input  wire logic                           a_wr_en,
    input  wire stream_pkg::word_t              a_data,
    output      logic                           a_full,
    output      logic [$clog2(DEPTH + 1)-1:0]   a_level,

    // Producer b
    input  wire logic                           b_wr_en,
    input  wire stream_pkg::word_t              b_data,
    output      logic                           b_full,
    output      logic [$clog2(DEPTH + 1)-1:0]   b_level,

    // Merged output
    output      logic                           out_valid,
    output      stream_pkg::word_t              out_data,
    output      stream_pkg::chan_t              out_chan
);

    //////////////////////////////////////////////////////////////////////
    // Read-side links between the FIFOs and the merger
    //////////////////////////////////////////////////////////////////////

    fifo_rd_if #(
        .DEPTH (DEPTH)
    ) a_rd ();

    fifo_rd_if #(
        .DEPTH (DEPTH)
    ) b_rd ();

    // Occupancy visible to the producers
    assign a_level = a_rd.level;
    assign b_level = b_rd.level;

    //////////////////////////////////////////////////////////////////////
    // Channel FIFOs
    //////////////////////////////////////////////////////////////////////

    // Channel a
    sync_fifo #(
        .DEPTH   (DEPTH)
    ) u_fifo_a (
        .clk     (clk),
        .rst_n   (rst_n),
        .wr_en   (a_wr_en),
        .wr_data (a_data),
        .full    (a_full),
        .rd      (a_rd)
    );

    // Channel b
    sync_fifo #(
        .DEPTH   (DEPTH)
    ) u_fifo_b (
        .clk     (clk),
        .rst_n   (rst_n),
        .wr_en   (b_wr_en),
        .wr_data (b_data),
        .full    (b_full),
        .rd      (b_rd)
    );

    //////////////////////////////////////////////////////////////////////
    // Merger
    //////////////////////////////////////////////////////////////////////

    // Drains both FIFOs and tags each word with its channel
    rr_merger u_merger (
        .clk       (clk),
        .rst_n     (rst_n),
        .a         (a_rd),
        .b         (b_rd),
        .out_valid (out_valid),
        .out_data  (out_data),
        .out_chan  (out_chan)
    );

endmodule

`default_nettype wire

//--- rr_merger.sv
`timescale 1ns/100ps
`default_nettype none

// Round-robin reader of two FIFOs
// Issues at most one read per cycle and emits the word one cycle later
// with a valid pulse and the source tag
module rr_merger (
    input  wire logic               clk,
    input  wire logic               rst_n,
    // Channel a FIFO read side
    fifo_rd_if.reader_side          a,
    // Channel b FIFO read side
    fifo_rd_if.reader_side          b,
    // Merged stream
    output      logic               out_valid,
    output      stream_pkg::word_t  out_data,
    output      stream_pkg::chan_t  out_chan
);

    //////////////////////////////////////////////////////////////////////
    // State
    //////////////////////////////////////////////////////////////////////

    // Channel served by the most recent read
    stream_pkg::grant_t last_q;

    // A read was accepted at the last edge
    logic pend_q;

    // Channel of that read selects the output word
    stream_pkg::chan_t sel_q;

    // High when channel b gets the current read
    logic pick_b;

    // Some read goes out this cycle
    logic any_rd;

    //////////////////////////////////////////////////////////////////////
    // Arbitration
    //////////////////////////////////////////////////////////////////////

    always_comb
    begin
        if (!a.empty && !b.empty)
        begin
            // Both backlogged so serve the one not taken last
            pick_b = (last_q == stream_pkg::GRANT_A);
        end
        else
        begin
            // Only one or none has data
            // With both empty no strobe is raised anyway
            pick_b = !b.empty;
        end
    end

    // Exactly one strobe whenever any FIFO has data
    assign a.rd_en = !a.empty && !pick_b;
    assign b.rd_en = !b.empty && pick_b;

    assign any_rd = a.rd_en || b.rd_en;

    //////////////////////////////////////////////////////////////////////
    // Grant and pending registers
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk or posedge rst_n)
    begin
        if (rst_n)
        begin
            // Channel a wins the first tie
            last_q <= stream_pkg::GRANT_B;
            pend_q <= 1'b0;
            sel_q  <= stream_pkg::CHAN_A;
        end
        else
        begin
            // Marks the cycle in which the FIFO register holds the word
            pend_q <= any_rd;

            if (any_rd)
            begin
                if (pick_b)
                begin
                    last_q <= stream_pkg::GRANT_B;
                    sel_q  <= stream_pkg::CHAN_B;
                end
                else
                begin
                    last_q <= stream_pkg::GRANT_A;
                    sel_q  <= stream_pkg::CHAN_A;
                end
            end
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Output stage
    //////////////////////////////////////////////////////////////////////

    // One-cycle pulse per word with no back-pressure
    assign out_valid = pend_q;

    assign out_chan = sel_q;

    // Read data of the chosen FIFO was loaded at the same edge as pend_q
    // A new read in this cycle only changes it at the next edge
    always_comb
    begin
        if (sel_q == stream_pkg::CHAN_B)
        begin
            out_data = b.rd_data;
        end
        else
        begin
            out_data = a.rd_data;
        end
    end

endmodule

`default_nettype wire

//--- sync_fifo.sv
`timescale 1ns/100ps
`default_nettype none

// Single clock FIFO with registered read data
// Occupancy counter runs 0..DEPTH and gives full and empty
module sync_fifo #(
    parameter int DEPTH = 8
) (
    input  wire logic              clk,
    input  wire logic              rst_n,
    // Write side straight from the producer
    input  wire logic              wr_en,
    input  wire stream_pkg::word_t wr_data,
    output      logic              full,
    // Read side toward the merger
    fifo_rd_if.fifo_side           rd
);

    //////////////////////////////////////////////////////////////////////
    // Sizes
    //////////////////////////////////////////////////////////////////////

    // Pointers wrap by overflow since DEPTH is a power of two
    localparam int PTR_BITS = $clog2(DEPTH);
    // Counter must also hold DEPTH itself
    localparam int LVL_BITS = $clog2(DEPTH + 1);

    // Storage for DEPTH words
    stream_pkg::word_t mem [DEPTH];

    // Next slot to write and next slot to read
    logic [PTR_BITS-1:0] wr_ptr;
    logic [PTR_BITS-1:0] rd_ptr;

    // Number of stored words
    logic [LVL_BITS-1:0] count;

    // Accepted accesses this cycle
    logic wr_ok;
    logic rd_ok;

    //////////////////////////////////////////////////////////////////////
    // Status flags
    //////////////////////////////////////////////////////////////////////

    // Flags follow the counter with no extra delay
    assign full     = (count == LVL_BITS'(DEPTH));
    assign rd.empty = (count == '0);
    assign rd.level = count;

    // A write while full is lost even if a read happens too
    assign wr_ok = wr_en && !full;
    // A read while empty does nothing
    assign rd_ok = rd.rd_en && !rd.empty;

    //////////////////////////////////////////////////////////////////////
    // Occupancy counter
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk or posedge rst_n)
    begin
        if (rst_n)
        begin
            count <= '0;
        end
        else
        begin
            case ({wr_ok, rd_ok})
                // Write alone
                2'b10: count <= count + 1'b1;
                // Read alone
                2'b01: count <= count - 1'b1;
                // Both or neither leave the count alone
                default: count <= count;
            endcase
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Pointers
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk or posedge rst_n)
    begin
        if (rst_n)
        begin
            wr_ptr <= '0;
            rd_ptr <= '0;
        end
        else
        begin
            // Advance on accepted write
            if (wr_ok)
            begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            // Advance on accepted read
            if (rd_ok)
            begin
                rd_ptr <= rd_ptr + 1'b1;
            end
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Memory and read register
    //////////////////////////////////////////////////////////////////////

    // Store the incoming word at the write slot
    always_ff @(posedge clk)
    begin
        if (wr_ok)
        begin
            mem[wr_ptr] <= wr_data;
        end
    end

    // Head word moves into the output register on an accepted read
    // and holds otherwise
    always_ff @(posedge clk or posedge rst_n)
    begin
        if (rst_n)
        begin
            rd.rd_data <= '0;
        end
        else if (rd_ok)
        begin
            rd.rd_data <= mem[rd_ptr];
        end
    end

endmodule

`default_nettype wire

//--- fifo_rd_if.sv
`timescale 1ns/100ps
`default_nettype none

// Read side of one FIFO
// Level and empty come from the occupancy counter inside the FIFO
interface fifo_rd_if #(
    parameter int DEPTH = 8
);

    // Enough bits to hold 0 up to DEPTH
    localparam int LVL_BITS = $clog2(DEPTH + 1);

    // Read strobe from the reader
    logic rd_en;
    // Registered head word that is valid the cycle after an accepted read
    stream_pkg::word_t rd_data;
    // Nothing left to read
    logic empty;
    // Current occupancy
    logic [LVL_BITS-1:0] level;

    // FIFO owns data and status
    modport fifo_side (
        input  rd_en,
        output rd_data,
        output empty,
        output level
    );

    // Reader owns the strobe
    modport reader_side (
        output rd_en,
        input  rd_data,
        input  empty,
        input  level
    );

endinterface

`default_nettype wire

//--- stream_pkg.sv
`default_nettype none

//////////////////////////////////////////////////////////////////////
// Shared types for the dual stream merger
//////////////////////////////////////////////////////////////////////

package stream_pkg;

    // Width of one data word on every stream
    parameter int WORD_BITS = 8;

    // One data word as pushed by a producer
    typedef logic [WORD_BITS-1:0] word_t;

    // Source tag on the merged output
    // 0 marks channel a, 1 marks channel b
    typedef logic [0:0] chan_t;

    localparam chan_t CHAN_A = 1'b0;
    localparam chan_t CHAN_B = 1'b1;

    //////////////////////////////////////////////////////////////////////
    // Merger arbitration state
    //////////////////////////////////////////////////////////////////////

    // Channel that the merger served last
    typedef enum logic
    {
        GRANT_A = 1'b0,
        GRANT_B = 1'b1
    } grant_t;

endpackage

`default_nettype wire
